//--- logic/hm_rx.sv
`timescale 1ns/10ps
`include "hm_settings.svh"

module hm_rx (
	input logic trn_clk,
	input logic reset,
	input hm_types_pkg::trn_data_t trn_rx_data,
	input logic trn_rx_sof,
	input logic trn_rx_eof,
	input logic trn_rx_src_rdy,
	input logic trn_lnk_up_n,
	output logic trn_reset,
	output logic write_bar,
	output logic read_exp,
	output logic hm_end,
	output logic rx_timeout,
	output logic frame_ok,
	output logic frame_drop,
	output logic cpl_req,
	output hm_types_pkg::trn_data_t cpl_addr,
	output hm_types_pkg::status_t state_rx,
	input logic tx_busy
);

	import hm_types_pkg::*;
	import hm_state_pkg::*;

	localparam int IDLE_W = $clog2(`HM_RX_TIMEOUT) + 1;

	logic reset_meta;
	rx_state_e state;
	frame_type_t frame_type;
	logic link_down;
	logic [IDLE_W-1:0] idle_cnt;
	logic sof_beat;
	logic eof_beat;
	logic expired;
	logic drop_now;

	// reset retimed into trn_clk.
	always_ff @(posedge trn_clk) begin
		reset_meta <= reset;
		trn_reset <= reset_meta;
	end

	assign sof_beat = trn_rx_src_rdy & trn_rx_sof;
	assign eof_beat = trn_rx_src_rdy & trn_rx_eof;
	assign expired = !trn_rx_src_rdy && (idle_cnt == IDLE_W'(`HM_RX_TIMEOUT - 1));

	// link down at sof, or a read the completer cannot take.
	assign drop_now = link_down || (frame_type == FT_READ_EXP && tx_busy);

	always_ff @(posedge trn_clk) begin
		write_bar <= 1'b0;
		read_exp <= 1'b0;
		hm_end <= 1'b0;
		rx_timeout <= 1'b0;
		frame_ok <= 1'b0;
		frame_drop <= 1'b0;
		if (trn_reset) begin
			state <= RX_IDLE;
			frame_type <= FT_OTHER;
			link_down <= 1'b1;
			idle_cnt <= '0;
		end else begin
			case (state)
				RX_IDLE, RX_DROP: begin
					if (sof_beat) begin
						state <= RX_FRAME;
						frame_type <= frame_type_t'(trn_rx_data[31:30]);
						link_down <= trn_lnk_up_n;
						idle_cnt <= '0;
					end else if (state == RX_DROP && eof_beat) begin
						state <= RX_IDLE; // tail of the timed out frame.
					end
				end
				RX_FRAME: begin
					if (eof_beat) begin
						state <= RX_IDLE;
						if (drop_now) begin
							frame_drop <= 1'b1;
						end else begin
							frame_ok <= 1'b1;
							write_bar <= (frame_type == FT_WRITE_BAR);
							read_exp <= (frame_type == FT_READ_EXP);
							hm_end <= (frame_type == FT_END);
						end
					end else if (expired) begin
						state <= RX_DROP;
						rx_timeout <= 1'b1;
						frame_drop <= 1'b1;
					end else if (trn_rx_src_rdy) begin
						idle_cnt <= '0;
					end else begin
						idle_cnt <= idle_cnt + 1'b1;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// address beat, kept for the completion.
	always_ff @(posedge trn_clk) begin
		if (state == RX_FRAME && eof_beat)
			cpl_addr <= trn_rx_data;
	end

	assign cpl_req = read_exp;
	assign state_rx = status_t'(state);

endmodule

//--- logic/hm_settings.svh
`ifndef HM_SETTINGS_SVH
`define HM_SETTINGS_SVH

// trn cycles a frame may sit without a valid beat.
`define HM_RX_TIMEOUT 16

// trn cycles the completer waits on dst_rdy per beat.
`define HM_TX_TIMEOUT 32

// first word of every completion frame.
`define HM_CPL_HEADER 32'h4a00_0001

`define HM_CNT_WIDTH 32

`endif

//--- logic/hm_state_pkg.sv
package hm_state_pkg;

	// idle is zero in every machine.
	typedef enum logic [1:0] {
		RX_IDLE = 2'b00,
		RX_FRAME = 2'b01, // bit 0 set while a frame is open.
		RX_DROP = 2'b10
	} rx_state_e;

	typedef enum logic [1:0] {
		TX_IDLE = 2'b00,
		TX_HDR = 2'b01,
		TX_DATA = 2'b10
	} tx_state_e;

	typedef enum logic [1:0] {
		HM_DOWN = 2'b00,
		HM_UP = 2'b01,
		HM_BUSY = 2'b10
	} hm_state_e;

endpackage

//--- logic/hm_stats.sv
`timescale 1ns/10ps

module hm_stats (
	input logic trn_clk,
	input logic trn_reset,
	input logic frame_ok,
	input logic frame_drop,
	input logic cpl_done,
	input logic trn_lnk_up_n,
	input logic rx_busy,
	input logic tx_busy,
	output hm_types_pkg::stat_cnt_t cpt_rx_gray,
	output hm_types_pkg::stat_cnt_t cpt_tx_gray,
	output hm_types_pkg::stat_cnt_t cpt_drop_gray,
	output hm_types_pkg::status_t state
);

	import hm_types_pkg::*;
	import hm_state_pkg::*;

	stat_cnt_t cnt_rx;
	stat_cnt_t cnt_tx;
	stat_cnt_t cnt_drop;
	hm_state_e hm_state;

	always_ff @(posedge trn_clk) begin
		if (trn_reset) begin
			cnt_rx <= '0;
			cnt_tx <= '0;
			cnt_drop <= '0;
			cpt_rx_gray <= '0;
			cpt_tx_gray <= '0;
			cpt_drop_gray <= '0;
			hm_state <= HM_DOWN;
		end else begin
			if (frame_ok)
				cnt_rx <= cnt_rx + 1'b1;
			if (cpl_done)
				cnt_tx <= cnt_tx + 1'b1;
			if (frame_drop)
				cnt_drop <= cnt_drop + 1'b1;
			// one bit flips per step, safe to sample from sys_clk.
			cpt_rx_gray <= cnt_rx ^ (cnt_rx >> 1);
			cpt_tx_gray <= cnt_tx ^ (cnt_tx >> 1);
			cpt_drop_gray <= cnt_drop ^ (cnt_drop >> 1);
			if (trn_lnk_up_n)
				hm_state <= HM_DOWN;
			else if (rx_busy || tx_busy)
				hm_state <= HM_BUSY;
			else
				hm_state <= HM_UP;
		end
	end

	assign state = status_t'(hm_state);

endmodule

//--- logic/hm_sync.sv
`timescale 1ns/10ps
`include "hm_settings.svh"

module hm_sync (
	input logic sys_clk,
	input logic reset,
	input logic trn_clk,
	input logic trn_reset,
	input logic rx_timeout,
	input logic tx_timeout,
	input logic hm_end,
	input logic write_bar,
	input logic read_exp,
	input logic trn_lnk_up_n,
	input hm_types_pkg::status_t state_rx,
	input hm_types_pkg::status_t state_tx,
	input hm_types_pkg::status_t state,
	input hm_types_pkg::stat_cnt_t cpt_rx_gray,
	input hm_types_pkg::stat_cnt_t cpt_tx_gray,
	input hm_types_pkg::stat_cnt_t cpt_drop_gray,
	output logic sys_rx_timeout,
	output logic sys_tx_timeout,
	output logic sys_hm_end,
	output logic sys_write_bar,
	output logic sys_read_exp,
	output logic sys_trn_lnk_up_n,
	output hm_types_pkg::status_t sys_state_rx,
	output hm_types_pkg::status_t sys_state_tx,
	output hm_types_pkg::status_t sys_state,
	output hm_types_pkg::stat_cnt_t sys_stat_cpt_rx,
	output hm_types_pkg::stat_cnt_t sys_stat_cpt_tx,
	output hm_types_pkg::stat_cnt_t sys_stat_cpt_drop
);

	import hm_types_pkg::*;
	import hm_state_pkg::*;

	logic lnk_meta;
	status_t state_rx_meta;
	status_t state_tx_meta;
	status_t state_meta;
	stat_cnt_t rx_meta;
	stat_cnt_t tx_meta;
	stat_cnt_t drop_meta;
	stat_cnt_t rx_sync;
	stat_cnt_t tx_sync;
	stat_cnt_t drop_sync;

	function automatic stat_cnt_t gray_to_bin(input stat_cnt_t g);
		stat_cnt_t b;
		b[`HM_CNT_WIDTH-1] = g[`HM_CNT_WIDTH-1];
		for (int k = `HM_CNT_WIDTH - 2; k >= 0; k--)
			b[k] = b[k+1] ^ g[k];
		return b;
	endfunction

	psync ps_rx_timeout (.clk1(trn_clk), .reset1(trn_reset), .i(rx_timeout),
		.clk2(sys_clk), .reset2(reset), .o(sys_rx_timeout));
	psync ps_tx_timeout (.clk1(trn_clk), .reset1(trn_reset), .i(tx_timeout),
		.clk2(sys_clk), .reset2(reset), .o(sys_tx_timeout));
	psync ps_hm_end (.clk1(trn_clk), .reset1(trn_reset), .i(hm_end),
		.clk2(sys_clk), .reset2(reset), .o(sys_hm_end));
	psync ps_write_bar (.clk1(trn_clk), .reset1(trn_reset), .i(write_bar),
		.clk2(sys_clk), .reset2(reset), .o(sys_write_bar));
	psync ps_read_exp (.clk1(trn_clk), .reset1(trn_reset), .i(read_exp),
		.clk2(sys_clk), .reset2(reset), .o(sys_read_exp));

	// levels, two flops.
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			lnk_meta <= 1'b1;
			state_rx_meta <= status_t'(RX_IDLE);
			state_tx_meta <= status_t'(TX_IDLE);
			state_meta <= status_t'(HM_DOWN);
			sys_trn_lnk_up_n <= 1'b1;
			sys_state_rx <= status_t'(RX_IDLE);
			sys_state_tx <= status_t'(TX_IDLE);
			sys_state <= status_t'(HM_DOWN);
		end else begin
			lnk_meta <= trn_lnk_up_n;
			state_rx_meta <= state_rx;
			state_tx_meta <= state_tx;
			state_meta <= state;
			sys_trn_lnk_up_n <= lnk_meta;
			sys_state_rx <= state_rx_meta;
			sys_state_tx <= state_tx_meta;
			sys_state <= state_meta;
		end
	end

	// gray counters, two flops then back to binary.
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			rx_meta <= '0;
			tx_meta <= '0;
			drop_meta <= '0;
			rx_sync <= '0;
			tx_sync <= '0;
			drop_sync <= '0;
			sys_stat_cpt_rx <= '0;
			sys_stat_cpt_tx <= '0;
			sys_stat_cpt_drop <= '0;
		end else begin
			rx_meta <= cpt_rx_gray;
			tx_meta <= cpt_tx_gray;
			drop_meta <= cpt_drop_gray;
			rx_sync <= rx_meta;
			tx_sync <= tx_meta;
			drop_sync <= drop_meta;
			sys_stat_cpt_rx <= gray_to_bin(rx_sync);
			sys_stat_cpt_tx <= gray_to_bin(tx_sync);
			sys_stat_cpt_drop <= gray_to_bin(drop_sync);
		end
	end

endmodule

//--- logic/hm_top.sv
`timescale 1ns/10ps

module hm_top (
	input logic sys_clk,
	input logic trn_clk,
	input logic reset,
	input hm_types_pkg::trn_data_t trn_rx_data,
	input logic trn_rx_sof,
	input logic trn_rx_eof,
	input logic trn_rx_src_rdy,
	input logic trn_lnk_up_n,
	output hm_types_pkg::trn_data_t trn_tx_data,
	output logic trn_tx_sof,
	output logic trn_tx_eof,
	output logic trn_tx_src_rdy,
	input logic trn_tx_dst_rdy,
	output logic sys_rx_timeout,
	output logic sys_tx_timeout,
	output logic sys_hm_end,
	output logic sys_write_bar,
	output logic sys_read_exp,
	output logic sys_trn_lnk_up_n,
	output hm_types_pkg::status_t sys_state_rx,
	output hm_types_pkg::status_t sys_state_tx,
	output hm_types_pkg::status_t sys_state,
	output hm_types_pkg::stat_cnt_t sys_stat_cpt_rx,
	output hm_types_pkg::stat_cnt_t sys_stat_cpt_tx,
	output hm_types_pkg::stat_cnt_t sys_stat_cpt_drop
);

	import hm_types_pkg::*;

	logic trn_reset;
	logic write_bar;
	logic read_exp;
	logic hm_end;
	logic rx_timeout;
	logic tx_timeout;
	logic frame_ok;
	logic frame_drop;
	logic cpl_req;
	logic cpl_done;
	logic tx_busy;
	trn_data_t cpl_addr;
	status_t state_rx;
	status_t state_tx;
	status_t state;
	stat_cnt_t cpt_rx_gray;
	stat_cnt_t cpt_tx_gray;
	stat_cnt_t cpt_drop_gray;

	hm_rx hm_rx_i (.*);

	hm_tx hm_tx_i (.*);

	// bit 0 of the rx state is set only in RX_FRAME.
	hm_stats hm_stats_i (
		.*,
		.rx_busy(state_rx[0])
	);

	hm_sync hm_sync_i (.*);

endmodule

//--- logic/hm_tx.sv
`timescale 1ns/10ps
`include "hm_settings.svh"

module hm_tx (
	input logic trn_clk,
	input logic trn_reset,
	input logic cpl_req,
	input hm_types_pkg::trn_data_t cpl_addr,
	output hm_types_pkg::trn_data_t trn_tx_data,
	output logic trn_tx_sof,
	output logic trn_tx_eof,
	output logic trn_tx_src_rdy,
	input logic trn_tx_dst_rdy,
	output logic tx_busy,
	output logic cpl_done,
	output logic tx_timeout,
	output hm_types_pkg::status_t state_tx
);

	import hm_types_pkg::*;
	import hm_state_pkg::*;

	localparam int WAIT_W = $clog2(`HM_TX_TIMEOUT) + 1;

	tx_state_e state;
	trn_data_t addr_q;
	logic [WAIT_W-1:0] wait_cnt;
	logic expired;

	assign expired = !trn_tx_dst_rdy && (wait_cnt == WAIT_W'(`HM_TX_TIMEOUT - 1));

	always_ff @(posedge trn_clk) begin
		cpl_done <= 1'b0;
		tx_timeout <= 1'b0;
		if (trn_reset) begin
			state <= TX_IDLE;
			wait_cnt <= '0;
		end else begin
			case (state)
				TX_IDLE: begin
					if (cpl_req) begin
						state <= TX_HDR;
						wait_cnt <= '0;
					end
				end
				TX_HDR, TX_DATA: begin
					if (trn_tx_dst_rdy) begin
						wait_cnt <= '0; // fresh wait for the next beat.
						if (state == TX_HDR) begin
							state <= TX_DATA;
						end else begin
							state <= TX_IDLE;
							cpl_done <= 1'b1;
						end
					end else if (expired) begin
						state <= TX_IDLE; // frame abandoned.
						tx_timeout <= 1'b1;
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge trn_clk) begin
		if (state == TX_IDLE && cpl_req)
			addr_q <= cpl_addr;
	end

	assign trn_tx_src_rdy = (state != TX_IDLE);
	assign trn_tx_sof = (state == TX_HDR);
	assign trn_tx_eof = (state == TX_DATA);
	assign trn_tx_data = (state == TX_HDR) ? `HM_CPL_HEADER : addr_q;
	assign tx_busy = (state != TX_IDLE);
	assign state_tx = status_t'(state);

endmodule

//--- logic/hm_types_pkg.sv
`include "hm_settings.svh"

package hm_types_pkg;

	typedef logic [31:0] trn_data_t;

	// type field, header bits 31:30.
	typedef logic [1:0] frame_type_t;

	typedef logic [`HM_CNT_WIDTH-1:0] stat_cnt_t;

	// fsm state as seen on the status ports.
	typedef logic [1:0] status_t;

	localparam frame_type_t FT_OTHER = 2'd0;
	localparam frame_type_t FT_WRITE_BAR = 2'd1;
	localparam frame_type_t FT_READ_EXP = 2'd2;
	localparam frame_type_t FT_END = 2'd3;

endpackage

//--- logic/psync.sv
`timescale 1ns/10ps

module psync (
	input logic clk1,
	input logic reset1,
	input logic i,
	input logic clk2,
	input logic reset2,
	output logic o
);

	logic toggle;
	logic [2:0] sync;

	// one toggle per source pulse.
	always_ff @(posedge clk1) begin
		if (reset1)
			toggle <= 1'b0;
		else if (i)
			toggle <= ~toggle;
	end

	always_ff @(posedge clk2) begin
		if (reset2)
			sync <= '0;
		else
			sync <= {sync[1:0], toggle};
	end

	assign o = sync[2] ^ sync[1]; // edge of the synced toggle.

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the hm_top simulation with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps -f src.f --top-module hm_tb -o hm_sim

out=$(./obj_dir/hm_sim)
echo "$out"

if echo "$out" | grep -qx "TEST PASSED"; then
	exit 0
fi
exit 1

//--- src.f
+incdir+logic
logic/hm_types_pkg.sv
logic/hm_state_pkg.sv
logic/psync.sv
logic/hm_rx.sv
logic/hm_tx.sv
logic/hm_stats.sv
logic/hm_sync.sv
logic/hm_top.sv
testbench/hm_checker.sv
testbench/hm_tb.sv

//--- testbench/hm_checker.sv
`timescale 1ns/10ps
`include "hm_settings.svh"

module hm_checker (
	input logic sys_clk,
	input logic trn_clk,
	input logic reset,
	input logic start,
	input logic done,
	input logic reset_chk,
	input int row_idx,
	input hm_types_pkg::frame_type_t row_type,
	input hm_types_pkg::trn_data_t row_addr,
	input logic row_link_n,
	input logic row_ok,
	input logic row_drop,
	input logic row_rxto,
	input logic [1:0] row_cpl,
	input hm_types_pkg::trn_data_t trn_tx_data,
	input logic trn_tx_sof,
	input logic trn_tx_eof,
	input logic trn_tx_src_rdy,
	input logic trn_tx_dst_rdy,
	input logic sys_rx_timeout,
	input logic sys_tx_timeout,
	input logic sys_hm_end,
	input logic sys_write_bar,
	input logic sys_read_exp,
	input logic sys_trn_lnk_up_n,
	input hm_types_pkg::status_t sys_state_rx,
	input hm_types_pkg::status_t sys_state_tx,
	input hm_types_pkg::status_t sys_state,
	input hm_types_pkg::stat_cnt_t sys_stat_cpt_rx,
	input hm_types_pkg::stat_cnt_t sys_stat_cpt_tx,
	input hm_types_pkg::stat_cnt_t sys_stat_cpt_drop,
	output logic settled,
	output int tests,
	output int failed,
	output int errors
);

	import hm_types_pkg::*;
	import hm_state_pkg::*;

	stat_cnt_t exp_rx;
	stat_cnt_t exp_tx;
	stat_cnt_t exp_drop;
	logic [4:0] pulses;
	int n_pulse [5];
	int e_pulse [5];
	int e_beats;
	int tx_beats = 0;
	int tx_bad = 0;
	int tx_base;
	int bad_base;
	int row_err;
	logic hdr_seen = 1'b0;

	assign pulses = {sys_tx_timeout, sys_rx_timeout, sys_hm_end, sys_read_exp, sys_write_bar};

	function automatic string pulse_name(input int k);
		case (k)
			0: return "sys_write_bar";
			1: return "sys_read_exp";
			2: return "sys_hm_end";
			3: return "sys_rx_timeout";
			default: return "sys_tx_timeout";
		endcase
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			$display("error %s expected %h got %h", name, want, got);
			row_err++;
		end
	endtask

	task automatic close_test(input string what);
		tests++;
		errors += row_err;
		if (row_err != 0) begin
			failed++;
			$display("test %0d %s %0d: failed, %0d mismatches", tests, what, row_idx, row_err);
		end else begin
			$display("test %0d %s %0d type %0d: ok", tests, what, row_idx, row_type);
		end
	endtask

	task automatic check_reset();
		row_err = 0;
		for (int k = 0; k < 5; k++)
			compare(pulse_name(k), n_pulse[k], 0);
		compare("sys_stat_cpt_rx", sys_stat_cpt_rx, '0);
		compare("sys_stat_cpt_tx", sys_stat_cpt_tx, '0);
		compare("sys_stat_cpt_drop", sys_stat_cpt_drop, '0);
		compare("sys_state_rx", 32'(sys_state_rx), 32'(RX_IDLE));
		compare("sys_state_tx", 32'(sys_state_tx), 32'(TX_IDLE));
		compare("sys_state", 32'(sys_state), 32'(HM_DOWN)); // link held down.
		compare("sys_trn_lnk_up_n", 32'(sys_trn_lnk_up_n), 32'd1);
		compare("trn_tx beat count", tx_beats - tx_base, 0);
		row_err += tx_bad - bad_base;
		close_test("reset");
		tx_base = tx_beats;
		bad_base = tx_bad;
	endtask

	task automatic check_row();
		row_err = 0;
		for (int k = 0; k < 5; k++)
			compare(pulse_name(k), n_pulse[k], e_pulse[k]);
		compare("sys_stat_cpt_rx", sys_stat_cpt_rx, exp_rx);
		compare("sys_stat_cpt_tx", sys_stat_cpt_tx, exp_tx);
		compare("sys_stat_cpt_drop", sys_stat_cpt_drop, exp_drop);
		compare("trn_tx beat count", tx_beats - tx_base, e_beats);
		compare("sys_trn_lnk_up_n", 32'(sys_trn_lnk_up_n), 32'(row_link_n));
		compare("sys_state", 32'(sys_state), row_link_n ? 32'(HM_DOWN) : 32'(HM_UP));
		compare("sys_state_rx", 32'(sys_state_rx), 32'(RX_IDLE));
		compare("sys_state_tx", 32'(sys_state_tx), 32'(TX_IDLE));
		row_err += tx_bad - bad_base; // bad completion beats since the last check.
		close_test("row");
		tx_base = tx_beats;
		bad_base = tx_bad;
	endtask

	// accepted completion beats.
	always @(negedge trn_clk) begin
		if (trn_tx_src_rdy === 1'b1 && trn_tx_dst_rdy === 1'b1) begin
			tx_beats++;
			if (trn_tx_sof) begin
				hdr_seen = 1'b1;
				if (trn_tx_data !== `HM_CPL_HEADER) begin
					$display("error trn_tx_data expected %h got %h", `HM_CPL_HEADER, trn_tx_data);
					tx_bad++;
				end
			end else if (trn_tx_eof && hdr_seen) begin
				hdr_seen = 1'b0;
				if (trn_tx_data !== row_addr) begin
					$display("error trn_tx_data expected %h got %h", row_addr, trn_tx_data);
					tx_bad++;
				end
			end else begin
				$display("completion beat arrived without a header before it");
				tx_bad++;
			end
		end
	end

	always @(negedge sys_clk) begin
		if (reset) begin
			exp_rx = '0;
			exp_tx = '0;
			exp_drop = '0;
			e_beats = 0;
			for (int k = 0; k < 5; k++) begin
				n_pulse[k] = 0;
				e_pulse[k] = 0;
			end
			tx_base = tx_beats;
			bad_base = tx_bad;
			tests = 0;
			failed = 0;
			errors = 0;
		end else if (start) begin
			for (int k = 0; k < 5; k++)
				n_pulse[k] = 0;
			e_pulse[0] = (row_ok && row_type == FT_WRITE_BAR) ? 1 : 0;
			e_pulse[1] = (row_ok && row_type == FT_READ_EXP) ? 1 : 0;
			e_pulse[2] = (row_ok && row_type == FT_END) ? 1 : 0;
			e_pulse[3] = row_rxto ? 1 : 0;
			e_pulse[4] = (row_cpl == 2'd2) ? 1 : 0;
			e_beats = (row_cpl == 2'd1) ? 2 : 0; // header then address.
			if (row_ok)
				exp_rx = exp_rx + 1'b1;
			if (row_cpl == 2'd1)
				exp_tx = exp_tx + 1'b1;
			if (row_drop)
				exp_drop = exp_drop + 1'b1;
		end else begin
			for (int k = 0; k < 5; k++)
				if (pulses[k] === 1'b1)
					n_pulse[k]++;
			if (done)
				check_row();
			if (reset_chk)
				check_reset();
		end
	end

	// everything the row should change has arrived.
	always_comb begin
		settled = (sys_stat_cpt_rx === exp_rx) && (sys_stat_cpt_tx === exp_tx)
			&& (sys_stat_cpt_drop === exp_drop) && (tx_beats - tx_base == e_beats)
			&& (sys_state_rx === status_t'(RX_IDLE)) && (sys_state_tx === status_t'(TX_IDLE));
		for (int k = 0; k < 5; k++)
			if (n_pulse[k] != e_pulse[k])
				settled = 1'b0;
	end

endmodule

//--- testbench/hm_tb.sv
`timescale 1ns/10ps

module hm_tb;

	import hm_types_pkg::*;

	localparam int NUM_ROWS = 12;
	localparam int ROW_LIMIT = 200; // sys cycles per row.
	localparam int CYCLE_LIMIT = NUM_ROWS * ROW_LIMIT + 100;
	localparam int RND = 255; // delay drawn from the lfsr.

	logic sys_clk = 1'b0;
	logic trn_clk = 1'b0;
	logic reset;
	trn_data_t trn_rx_data;
	logic trn_rx_sof;
	logic trn_rx_eof;
	logic trn_rx_src_rdy;
	logic trn_lnk_up_n;
	trn_data_t trn_tx_data;
	logic trn_tx_sof;
	logic trn_tx_eof;
	logic trn_tx_src_rdy;
	logic trn_tx_dst_rdy = 1'b0;
	logic sys_rx_timeout;
	logic sys_tx_timeout;
	logic sys_hm_end;
	logic sys_write_bar;
	logic sys_read_exp;
	logic sys_trn_lnk_up_n;
	status_t sys_state_rx;
	status_t sys_state_tx;
	status_t sys_state;
	stat_cnt_t sys_stat_cpt_rx;
	stat_cnt_t sys_stat_cpt_tx;
	stat_cnt_t sys_stat_cpt_drop;

	logic start;
	logic done;
	logic reset_chk;
	logic settled;
	int tests;
	int failed;
	int errors;
	int row_idx;
	frame_type_t row_type;
	trn_data_t row_addr;
	logic row_link_n;
	logic row_ok;
	logic row_drop;
	logic row_rxto;
	logic [1:0] row_cpl;
	int row_delay;
	int cycle_cnt = 0;
	int rdy_wait = 0;
	logic [31:0] lfsr = 32'hb776;

	// row fields type, address, gap, lnk_up_n, delay, then expected ok, drop, rxto, cpl.
	frame_type_t tab_type [NUM_ROWS];
	trn_data_t tab_addr [NUM_ROWS];
	int tab_gap [NUM_ROWS];
	logic tab_link_n [NUM_ROWS];
	int tab_delay [NUM_ROWS];
	logic [4:0] tab_exp [NUM_ROWS];

	hm_top hm_top_i (.*);

	hm_checker hm_checker_i (.*);

	always #20 sys_clk = ~sys_clk;
	always #8 trn_clk = ~trn_clk;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic random_delay(output int d);
		d = 0;
		for (int k = 0; k < 4; k++) begin
			d = (d << 1) | int'(lfsr[0]);
			lfsr = lfsr_step(lfsr);
		end
	endtask

	task automatic set_row(input int i, input frame_type_t ft, input trn_data_t addr,
			input int gap, input logic link_n, input int delay, input logic [4:0] expect_bits);
		tab_type[i] = ft;
		tab_addr[i] = addr;
		tab_gap[i] = gap;
		tab_link_n[i] = link_n;
		tab_delay[i] = delay;
		tab_exp[i] = expect_bits;
	endtask

	task automatic load_table();
		set_row(0, FT_WRITE_BAR, 32'h1000_0010, 0, 1'b0, 0, 5'b10_0_00);
		set_row(1, FT_READ_EXP, 32'h0000_0040, 2, 1'b0, RND, 5'b10_0_01);
		set_row(2, FT_END, 32'h0000_0000, 1, 1'b0, 0, 5'b10_0_00);
		set_row(3, FT_OTHER, 32'h2000_0004, 3, 1'b0, 0, 5'b10_0_00);
		set_row(4, FT_WRITE_BAR, 32'h1000_0020, 20, 1'b0, 0, 5'b01_1_00);
		set_row(5, FT_WRITE_BAR, 32'h1000_0030, 0, 1'b1, 0, 5'b01_0_00);
		set_row(6, FT_READ_EXP, 32'h0000_0080, 1, 1'b0, 40, 5'b10_0_10); // sink stalls.
		set_row(7, FT_READ_EXP, 32'h0000_00c0, 5, 1'b0, RND, 5'b10_0_01);
		set_row(8, FT_END, 32'h0000_0000, 2, 1'b1, 0, 5'b01_0_00);
		set_row(9, FT_READ_EXP, 32'h0000_0100, 15, 1'b0, RND, 5'b10_0_01);
		set_row(10, FT_WRITE_BAR, 32'h1000_0040, 16, 1'b0, 0, 5'b01_1_00);
		set_row(11, FT_READ_EXP, 32'h0000_0140, 0, 1'b0, RND, 5'b10_0_01);
	endtask

	task automatic send_frame(input frame_type_t ft, input trn_data_t addr, input int gap,
			input logic link_n);
		@(posedge trn_clk);
		trn_lnk_up_n <= link_n;
		trn_rx_data <= {ft, 30'h0ab0_0000};
		trn_rx_sof <= 1'b1;
		trn_rx_src_rdy <= 1'b1;
		repeat (gap) begin
			@(posedge trn_clk);
			trn_rx_sof <= 1'b0;
			trn_rx_src_rdy <= 1'b0;
		end
		@(posedge trn_clk);
		trn_rx_sof <= 1'b0;
		trn_rx_eof <= 1'b1;
		trn_rx_src_rdy <= 1'b1;
		trn_rx_data <= addr;
		@(posedge trn_clk);
		trn_rx_eof <= 1'b0;
		trn_rx_src_rdy <= 1'b0;
		trn_rx_data <= '0;
	endtask

	task automatic run_row(input int i);
		int waited;
		row_idx = i;
		row_type = tab_type[i];
		row_addr = tab_addr[i];
		row_link_n = tab_link_n[i];
		{row_ok, row_drop, row_rxto, row_cpl} = tab_exp[i];
		if (tab_delay[i] == RND)
			random_delay(row_delay);
		else
			row_delay = tab_delay[i];
		@(posedge sys_clk);
		start = 1'b1;
		@(posedge sys_clk);
		start = 1'b0;
		send_frame(tab_type[i], tab_addr[i], tab_gap[i], tab_link_n[i]);
		waited = 0;
		while (!settled && waited < ROW_LIMIT) begin
			@(posedge sys_clk);
			waited++;
		end
		repeat (8) @(posedge sys_clk); // room for a late extra pulse.
		done = 1'b1;
		@(posedge sys_clk);
		done = 1'b0;
	endtask

	// completion sink holds dst_rdy back row_delay cycles.
	always @(posedge trn_clk) begin
		if (trn_tx_src_rdy !== 1'b1) begin
			rdy_wait <= 0;
			trn_tx_dst_rdy <= 1'b0;
		end else if (rdy_wait >= row_delay) begin
			trn_tx_dst_rdy <= 1'b1;
		end else begin
			rdy_wait <= rdy_wait + 1;
		end
	end

	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == CYCLE_LIMIT) begin
			$display("run did not finish within %0d sys_clk cycles", CYCLE_LIMIT);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		reset = 1'b1;
		trn_rx_data = '0;
		trn_rx_sof = 1'b0;
		trn_rx_eof = 1'b0;
		trn_rx_src_rdy = 1'b0;
		trn_lnk_up_n = 1'b1;
		start = 1'b0;
		done = 1'b0;
		reset_chk = 1'b0;
		row_idx = 0;
		row_type = FT_OTHER;
		row_addr = '0;
		row_link_n = 1'b1;
		{row_ok, row_drop, row_rxto, row_cpl} = 5'b0;
		row_delay = 0;
		load_table();
		repeat (5) @(posedge sys_clk);
		reset <= 1'b0;
		repeat (10) @(posedge sys_clk);
		reset_chk = 1'b1;
		@(posedge sys_clk);
		reset_chk = 1'b0;
		for (int i = 0; i < NUM_ROWS; i++)
			run_row(i);
		repeat (2) @(posedge sys_clk);
		$display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
		if (errors == 0 && tests == NUM_ROWS + 1)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule
